// File: sim/spw_link_golden.txt
# op value: W write word, T send time code, R read and expect word, E expect time code
# F fill burst of 40 bytes counting up from value, X random burst of value bytes; hex values
W 011
W 0a5
W 100
W 0ff
W 101
W 000
R 011
R 0a5
R 100
R 0ff
R 101
R 000
W 03c
T 2a
W 0c3
R 03c
E 2a
R 0c3
T 15
E 15
W 101
W 07e
W 100
R 101
R 07e
R 100
F 040
X 020
W 05a
R 05a

// File: sim/spw_link_tb.sv
`timescale 1ns/1ps

module spw_link_tb;
	import spw_pkg::*;

	localparam int unsigned bit_div = 4;
	localparam int unsigned fifo_depth = 16;
	localparam int unsigned fill_len = 40; // words in one fill burst
	localparam int unsigned idle_cycles = 200; // null-only window after reset
	localparam int unsigned chunk_len = 8; // random bytes per write/read round

	logic fpga_clk1_50;
	logic arst_n;
	logic din;
	logic sin;
	logic tx_write;
	spw_nchar_u tx_data;
	logic tick_in;
	logic [time_w-1:0] time_in;
	logic rx_read;
	logic dout;
	logic sout;
	logic tx_full;
	spw_nchar_u rx_data;
	logic rx_empty;
	logic tick_out;
	logic [time_w-1:0] time_out;
	logic parity_error;
	logic rx_overflow;

	byte op_q[$]; // opcode letters from the golden file
	logic [8:0] val_q[$]; // hex operands
	logic [time_w-1:0] tick_q[$]; // time values caught with tick_out
	int cycles = 0;
	int cycle_limit = 0; // set once the golden file is read
	logic saw_full; // tx_full observed during a burst
	logic [15:0] lfsr; // random state

	assign din = dout; // loopback
	assign sin = sout;

	spw_link_top #(.bit_div(bit_div), .fifo_depth(fifo_depth)) DUT (
		.fpga_clk1_50(fpga_clk1_50), .arst_n(arst_n),
		.din(din), .sin(sin),
		.tx_write(tx_write), .tx_data(tx_data),
		.tick_in(tick_in), .time_in(time_in), .rx_read(rx_read),
		.dout(dout), .sout(sout), .tx_full(tx_full),
		.rx_data(rx_data), .rx_empty(rx_empty),
		.tick_out(tick_out), .time_out(time_out),
		.parity_error(parity_error), .rx_overflow(rx_overflow)
	);

	initial fpga_clk1_50 = 1'b0;
	always #20 fpga_clk1_50 = ~fpga_clk1_50; // 40 ns period

	// watchdog
	always @(posedge fpga_clk1_50) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d clock cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped by the cycle limit");
		end
	end

	// tick monitor, a pulse is one cycle wide
	always @(negedge fpga_clk1_50) begin
		if (arst_n && tick_out) begin
			tick_q.push_back(time_out);
		end
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0d ns: %s got %0h expected %0h", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "first mismatch ends the run");
		end
	endtask

	// galois form, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [7:0] rand_byte();
		int k;
		for (k = 0; k < 8; k++) begin
			rand_byte[k] = lfsr[0]; // one step per bit taken
			lfsr = lfsr_step(lfsr);
		end
	endfunction

	task automatic write_word(input logic [8:0] w);
		@(negedge fpga_clk1_50);
		while (tx_full) begin
			saw_full = 1'b1; // stall on back-pressure
			@(negedge fpga_clk1_50);
		end
		@(posedge fpga_clk1_50);
		tx_write <= 1'b1;
		tx_data <= w;
		@(posedge fpga_clk1_50);
		tx_write <= 1'b0; // write taken on this edge
	endtask

	task automatic read_expect(input logic [8:0] exp);
		@(negedge fpga_clk1_50);
		while (rx_empty) begin
			@(negedge fpga_clk1_50); // wait for a word
		end
		check(rx_data, exp, "rx word");
		check(parity_error, 0, "parity error flag");
		@(posedge fpga_clk1_50);
		rx_read <= 1'b1;
		@(posedge fpga_clk1_50);
		rx_read <= 1'b0; // pop on this edge
	endtask

	task automatic send_time(input logic [time_w-1:0] t);
		@(posedge fpga_clk1_50);
		tick_in <= 1'b1;
		time_in <= t;
		@(posedge fpga_clk1_50);
		tick_in <= 1'b0;
	endtask

	task automatic expect_time(input logic [time_w-1:0] exp);
		logic [time_w-1:0] got;
		@(negedge fpga_clk1_50);
		while (tick_q.size() == 0) begin
			@(negedge fpga_clk1_50);
		end
		check(tick_q.size(), 1, "tick pulses per time code");
		got = tick_q.pop_front();
		check(got, exp, "time_out");
	endtask

	task automatic fill_burst(input logic [7:0] base);
		int i;
		saw_full = 1'b0;
		for (i = 0; i < fill_len; i++) begin
			write_word({1'b0, base + 8'(i)}); // no reads meanwhile
		end
		check(saw_full, 1, "tx_full seen during fill");
		while (!rx_overflow) begin
			@(negedge fpga_clk1_50);
		end
		// full tx fifo plus shifter, 10-bit chars, then line latency
		repeat ((fifo_depth + 2) * 10 * bit_div + 50) @(negedge fpga_clk1_50);
		for (i = 0; i < fifo_depth; i++) begin
			read_expect({1'b0, base + 8'(i)}); // oldest accepted words kept
		end
		@(negedge fpga_clk1_50);
		check(rx_empty, 1, "rx fifo empty after fill readout");
	endtask

	task automatic random_burst(input int count);
		logic [7:0] bytes[$];
		logic [7:0] b;
		int i;
		int k;
		int chunk;
		for (i = 0; i < count; i += chunk_len) begin
			bytes.delete();
			chunk = (count - i < chunk_len) ? count - i : chunk_len;
			for (k = 0; k < chunk; k++) begin
				b = rand_byte();
				bytes.push_back(b);
				write_word({1'b0, b});
			end
			for (k = 0; k < chunk; k++) begin
				read_expect({1'b0, bytes[k]}); // stays below rx depth
			end
		end
	endtask

	initial begin : main
		int fd;
		int n;
		int i;
		string line;
		string op_s;
		logic [8:0] val;
		arst_n = 1'b0;
		tx_write = 1'b0;
		tx_data = '0;
		tick_in = 1'b0;
		time_in = '0;
		rx_read = 1'b0;
		saw_full = 1'b0;
		lfsr = 16'd17; // seed
		fd = $fopen("sim/spw_link_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/spw_link_golden.txt for reading");
			$display("*** TEST FAILED ***");
			$fatal(1, "no stimulus file");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] != "#") begin // skip blanks and comments
				n = $sscanf(line, "%s %h", op_s, val);
				if (n == 2) begin
					op_q.push_back(op_s[0]);
					val_q.push_back(val);
				end
			end
		end
		$fclose(fd);
		cycle_limit = op_q.size() * 14 * bit_div * 4 + 2000;

		repeat (2) @(posedge fpga_clk1_50);
		arst_n <= 1'b1;
		@(negedge fpga_clk1_50);
		check(tx_full, 0, "tx_full after reset");
		check(rx_empty, 1, "rx_empty after reset");
		check(tick_out, 0, "tick_out after reset");
		check(parity_error, 0, "parity_error after reset");
		check(rx_overflow, 0, "rx_overflow after reset");
		check({dout, sout}, 0, "line after reset");
		repeat (idle_cycles) begin
			@(negedge fpga_clk1_50);
			check(rx_empty, 1, "rx_empty while link idles"); // nulls only
		end
		check(tick_q.size(), 0, "ticks while link idles");

		for (i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				"W": write_word(val_q[i]);
				"T": send_time(val_q[i][time_w-1:0]);
				"R": read_expect(val_q[i]);
				"E": expect_time(val_q[i][time_w-1:0]);
				"F": fill_burst(val_q[i][7:0]);
				"X": random_burst(int'(val_q[i]));
				default: begin
					$display("golden file entry %0d has an unknown opcode", i);
					$display("*** TEST FAILED ***");
					$fatal(1, "bad stimulus");
				end
			endcase
		end

		@(negedge fpga_clk1_50);
		check(tick_q.size(), 0, "unexpected tick pulses");
		check(parity_error, 0, "parity_error at end");
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: source/spw_char_decoder.sv
`timescale 1ns/1ps

module spw_char_decoder (
	input  logic                       fpga_clk1_50,
	input  logic                       arst_n,
	input  logic                       rx_bit_valid,
	input  logic                       rx_bit,
	input  logic                       fifo_full,
	output logic                       fifo_push,
	output spw_pkg::spw_nchar_u        fifo_wdata,
	output logic                       tick_out,
	output logic [spw_pkg::time_w-1:0] time_out,
	output logic                       parity_error,
	output logic                       rx_overflow
);
	import spw_pkg::*;

	logic [3:0] idx; // bits received of current char
	logic par_b; // received parity bit
	logic flag_b; // received control flag
	logic [7:0] pl; // payload shifter, enters at msb
	logic prev_par; // xor of previous payload
	logic esc_seen; // previous char was esc
	logic [7:0] pl_next; // payload including this bit
	logic [1:0] code; // control code of a finished control char
	logic last_bit; // this bit closes the char

	assign pl_next = {rx_bit, pl[7:1]}; // lsb first on the line
	assign code = pl_next[7:6]; // two shifts leave the code on top
	assign last_bit = rx_bit_valid && (flag_b ? (idx == 4'd3) : (idx == 4'd9));

	// bit assembly and parity
	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			idx <= '0;
			par_b <= 1'b0;
			flag_b <= 1'b0;
			pl <= '0;
			prev_par <= 1'b0; // matches encoder start value
			parity_error <= 1'b0;
		end else if (rx_bit_valid) begin
			if (idx == 4'd0) begin
				par_b <= rx_bit;
				idx <= 4'd1;
			end else if (idx == 4'd1) begin
				flag_b <= rx_bit; // sets char length
				idx <= 4'd2;
				if (!(prev_par ^ par_b ^ rx_bit)) begin
					parity_error <= 1'b1; // even count, sticky
				end
			end else begin
				pl <= pl_next;
				idx <= last_bit ? 4'd0 : idx + 1'b1;
				if (last_bit) begin
					prev_par <= flag_b ? ^pl_next[7:6] : ^pl_next;
				end
			end
		end
	end

	// classification and outputs, one cycle after the last bit
	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			fifo_push <= 1'b0;
			tick_out <= 1'b0;
			time_out <= '0;
			esc_seen <= 1'b0;
			rx_overflow <= 1'b0;
		end else begin
			fifo_push <= 1'b0; // single-cycle strobes
			tick_out <= 1'b0;
			if (last_bit) begin
				esc_seen <= 1'b0; // any char ends an esc pair
				if (!flag_b) begin
					if (esc_seen) begin
						tick_out <= 1'b1; // esc + data is a time code
						time_out <= pl_next[time_w-1:0];
					end else if (fifo_full) begin
						rx_overflow <= 1'b1; // data lost
					end else begin
						fifo_push <= 1'b1;
					end
				end else if (code == ctrl_esc) begin
					esc_seen <= 1'b1;
				end else if ((code == ctrl_eop || code == ctrl_eep) && !esc_seen) begin
					if (fifo_full) begin
						rx_overflow <= 1'b1; // marker lost
					end else begin
						fifo_push <= 1'b1;
					end
				end
				// fct and null fall through and are dropped
			end
		end
	end

	// fifo word, payload only
	always_ff @(posedge fpga_clk1_50) begin
		if (last_bit) begin
			if (!flag_b) begin
				fifo_wdata.dat.flag <= 1'b0;
				fifo_wdata.dat.data <= pl_next;
			end else begin
				fifo_wdata.mrk.flag <= 1'b1;
				fifo_wdata.mrk.code <= (code == ctrl_eep) ? marker_eep : marker_eop;
			end
		end
	end

	// decoder never writes into a full rx fifo
	a_push_not_full: assert property (@(posedge fpga_clk1_50) disable iff (!arst_n)
		fifo_push |-> !fifo_full)
		else $error("decoder pushed into a full fifo");

endmodule

// File: source/spw_char_encoder.sv
`timescale 1ns/1ps

module spw_char_encoder (
	input  logic                         fpga_clk1_50,
	input  logic                         arst_n,
	input  spw_pkg::spw_nchar_u          fifo_data,
	input  logic                         fifo_empty,
	input  logic                         tick_in,
	input  logic [spw_pkg::time_w-1:0]   time_in,
	input  logic                         bit_take,
	output logic                         fifo_pop,
	output logic                         bit_valid,
	output logic                         bit_value
);
	import spw_pkg::*;

	logic [9:0] sh; // bits still to send, lsb goes first
	logic [3:0] rem; // bits left in sh
	logic prev_par; // xor of previous payload
	logic time_pend; // time code waiting for its slot
	logic [time_w-1:0] time_val; // latest latched time
	logic follow_pend; // second half of an esc pair due
	logic follow_ctrl; // 1 follows with fct, 0 with time byte
	logic [7:0] follow_byte; // time byte after esc
	logic load; // shifter empty, pick next char
	logic nxt_ctrl; // next char is a control char
	logic [7:0] nxt_pl; // next payload, low 2 bits for control
	logic nxt_par; // parity bit of next char
	logic [9:0] nxt_sh;
	logic [3:0] nxt_len;

	assign load = (rem == '0);
	assign bit_valid = (rem != '0);
	assign bit_value = sh[0];
	assign fifo_pop = load && !follow_pend && !time_pend && !fifo_empty; // fifo is third in line

	// next char by priority
	always_comb begin
		if (follow_pend) begin
			nxt_ctrl = follow_ctrl; // fct for null, data for time code
			nxt_pl = follow_ctrl ? {6'd0, ctrl_fct} : follow_byte;
		end else if (time_pend) begin
			nxt_ctrl = 1'b1; // esc opens the time code
			nxt_pl = {6'd0, ctrl_esc};
		end else if (!fifo_empty) begin
			nxt_ctrl = fifo_data.dat.flag;
			if (fifo_data.dat.flag) begin
				nxt_pl = (fifo_data.mrk.code == marker_eep) ? {6'd0, ctrl_eep} : {6'd0, ctrl_eop};
			end else begin
				nxt_pl = fifo_data.dat.data;
			end
		end else begin
			nxt_ctrl = 1'b1; // idle, esc of a null
			nxt_pl = {6'd0, ctrl_esc};
		end
	end

	assign nxt_par = ~(prev_par ^ nxt_ctrl); // odd over prev payload, parity, flag
	assign nxt_sh = nxt_ctrl ? {6'd0, nxt_pl[1:0], 1'b1, nxt_par} : {nxt_pl, 1'b0, nxt_par};
	assign nxt_len = nxt_ctrl ? 4'd4 : 4'd10;

	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			sh <= '0;
			rem <= '0;
			prev_par <= 1'b0; // payload before first char counts as zero
			time_pend <= 1'b0;
			time_val <= '0;
			follow_pend <= 1'b0;
			follow_ctrl <= 1'b0;
			follow_byte <= '0;
		end else begin
			if (load) begin
				sh <= nxt_sh;
				rem <= nxt_len;
				prev_par <= nxt_ctrl ? ^nxt_pl[1:0] : ^nxt_pl;
				if (follow_pend) begin
					follow_pend <= 1'b0; // pair complete
				end else if (time_pend) begin
					follow_pend <= 1'b1;
					follow_ctrl <= 1'b0;
					follow_byte <= {2'b00, time_val}; // control bits zero
					time_pend <= 1'b0;
				end else if (fifo_empty) begin
					follow_pend <= 1'b1; // null needs its fct
					follow_ctrl <= 1'b1;
				end
			end else if (bit_take) begin
				sh <= sh >> 1; // next bit to the line
				rem <= rem - 1'b1;
			end
			if (tick_in) begin
				time_pend <= 1'b1; // newer tick replaces pending one
				time_val <= time_in;
			end
		end
	end

	// pop only when the tx fifo holds a word
	a_pop_not_empty: assert property (@(posedge fpga_clk1_50) disable iff (!arst_n)
		fifo_pop |-> !fifo_empty)
		else $error("encoder popped an empty fifo");

endmodule

// File: source/spw_ds_rx.sv
`timescale 1ns/1ps

module spw_ds_rx (
	input  logic fpga_clk1_50,
	input  logic arst_n,
	input  logic din,
	input  logic sin,
	output logic rx_bit_valid,
	output logic rx_bit
);

	logic din_s1; // first sync stage
	logic din_s2; // second sync stage
	logic sin_s1;
	logic sin_s2;
	logic ds_xor; // recovered bit clock
	logic ds_xor_q; // bit clock of previous cycle

	assign ds_xor = din_s2 ^ sin_s2;

	// two-flop synchronizers on both lines
	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			din_s1 <= 1'b0; // lines idle low after reset
			din_s2 <= 1'b0;
			sin_s1 <= 1'b0;
			sin_s2 <= 1'b0;
		end else begin
			din_s1 <= din;
			din_s2 <= din_s1;
			sin_s1 <= sin;
			sin_s2 <= sin_s1;
		end
	end

	// edge register
	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			ds_xor_q <= 1'b0;
			rx_bit_valid <= 1'b0;
			rx_bit <= 1'b0;
		end else begin
			ds_xor_q <= ds_xor;
			rx_bit_valid <= (ds_xor != ds_xor_q); // any edge of d xor s is a new bit
			rx_bit <= din_s2; // bit value is the data line
		end
	end

	// both lines toggling together would hide a bit
	a_one_line_in: assert property (@(posedge fpga_clk1_50) disable iff (!arst_n)
		!($changed(din_s2) && $changed(sin_s2)))
		else $error("din and sin changed together");

endmodule

// File: source/spw_ds_tx.sv
`timescale 1ns/1ps

module spw_ds_tx #(
	parameter int unsigned bit_div = 4 // clocks per bit, at least 3
) (
	input  logic fpga_clk1_50,
	input  logic arst_n,
	input  logic bit_valid,
	input  logic bit_value,
	output logic bit_take,
	output logic dout,
	output logic sout
);

	localparam int unsigned cnt_w = $clog2(bit_div);

	logic [cnt_w-1:0] cnt; // counts down to the next bit period

	assign bit_take = (cnt == '0); // start of a bit period

	// bit period counter
	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= cnt_w'(bit_div - 1); // first period ends bit_div cycles in
		end else if (bit_take) begin
			cnt <= cnt_w'(bit_div - 1);
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// data-strobe encoding
	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			dout <= 1'b0;
			sout <= 1'b0;
		end else if (bit_take && bit_valid) begin
			dout <= bit_value; // data carries the bit
			if (bit_value == dout) begin
				sout <= ~sout; // repeated bit, strobe flips
			end
		end
	end

	// exactly one line moves per bit
	a_one_line_moves: assert property (@(posedge fpga_clk1_50) disable iff (!arst_n)
		!($changed(dout) && $changed(sout)))
		else $error("dout and sout changed together");

endmodule

// File: source/spw_fifo.sv
`timescale 1ns/1ps

module spw_fifo #(
	parameter int unsigned fifo_depth = 16 // power of two
) (
	input  logic                        fpga_clk1_50,
	input  logic                        arst_n,
	input  logic                        push,
	input  logic                        pop,
	input  spw_pkg::spw_nchar_u         wdata,
	output spw_pkg::spw_nchar_u         rdata,
	output logic                        full,
	output logic                        empty,
	output logic [$clog2(fifo_depth):0] count
);
	import spw_pkg::*;

	localparam int unsigned addr_w = $clog2(fifo_depth);

	logic [nchar_w-1:0] mem [fifo_depth]; // word storage, raw bits
	logic [addr_w-1:0] wptr; // next slot to write
	logic [addr_w-1:0] rptr; // head slot
	logic [addr_w:0] cnt; // occupancy
	logic do_push;
	logic do_pop;

	assign full = (cnt == fifo_depth[addr_w:0]); // flags follow the count register
	assign empty = (cnt == '0);
	assign count = cnt;

	assign do_push = push && !full; // write into a full fifo is dropped
	assign do_pop = pop && !empty; // read of an empty fifo is dropped

	assign rdata = mem[rptr]; // first word fall-through

	// word storage
	always_ff @(posedge fpga_clk1_50) begin
		if (do_push) begin
			mem[wptr] <= wdata; // union stored as plain bits
		end
	end

	// pointers and count
	always_ff @(posedge fpga_clk1_50 or negedge arst_n) begin
		if (!arst_n) begin
			wptr <= '0;
			rptr <= '0;
			cnt <= '0;
		end else begin
			if (do_push) begin
				wptr <= wptr + 1'b1; // wraps at depth
			end
			if (do_pop) begin
				rptr <= rptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: cnt <= cnt + 1'b1;
				2'b01: cnt <= cnt - 1'b1;
				default: cnt <= cnt; // both or neither
			endcase
		end
	end

	// writer must respect full
	a_no_push_full: assert property (@(posedge fpga_clk1_50) disable iff (!arst_n)
		push |-> !full)
		else $error("spw_fifo push while full");

	// reader must respect empty
	a_no_pop_empty: assert property (@(posedge fpga_clk1_50) disable iff (!arst_n)
		pop |-> !empty)
		else $error("spw_fifo pop while empty");

endmodule

// File: source/spw_link_top.sv
`timescale 1ns/1ps

module spw_link_top #(
	parameter int unsigned bit_div = 4, // clocks per bit
	parameter int unsigned fifo_depth = 16 // both buffers
) (
	input  logic                       fpga_clk1_50,
	input  logic                       arst_n,
	input  logic                       din,
	input  logic                       sin,
	input  logic                       tx_write,
	input  spw_pkg::spw_nchar_u        tx_data,
	input  logic                       tick_in,
	input  logic [spw_pkg::time_w-1:0] time_in,
	input  logic                       rx_read,
	output logic                       dout,
	output logic                       sout,
	output logic                       tx_full,
	output spw_pkg::spw_nchar_u        rx_data,
	output logic                       rx_empty,
	output logic                       tick_out,
	output logic [spw_pkg::time_w-1:0] time_out,
	output logic                       parity_error,
	output logic                       rx_overflow
);
	import spw_pkg::*;

	spw_nchar_u tx_head; // tx fifo head to encoder
	spw_nchar_u rx_word; // decoder word to rx fifo
	logic tx_empty;
	logic tx_pop;
	logic bit_valid; // encoder to line driver
	logic bit_value;
	logic bit_take;
	logic rx_bit_valid; // line receiver to decoder
	logic rx_bit;
	logic rx_push;
	logic rx_full;

	spw_fifo #(.fifo_depth(fifo_depth)) tx_fifo (
		.fpga_clk1_50(fpga_clk1_50), .arst_n(arst_n),
		.push(tx_write), .pop(tx_pop), .wdata(tx_data),
		.rdata(tx_head), .full(tx_full), .empty(tx_empty), .count()
	);

	spw_char_encoder u_encoder (
		.fpga_clk1_50(fpga_clk1_50), .arst_n(arst_n),
		.fifo_data(tx_head), .fifo_empty(tx_empty),
		.tick_in(tick_in), .time_in(time_in), .bit_take(bit_take),
		.fifo_pop(tx_pop), .bit_valid(bit_valid), .bit_value(bit_value)
	);

	spw_ds_tx #(.bit_div(bit_div)) u_ds_tx (
		.fpga_clk1_50(fpga_clk1_50), .arst_n(arst_n),
		.bit_valid(bit_valid), .bit_value(bit_value),
		.bit_take(bit_take), .dout(dout), .sout(sout)
	);

	spw_ds_rx u_ds_rx (
		.fpga_clk1_50(fpga_clk1_50), .arst_n(arst_n),
		.din(din), .sin(sin),
		.rx_bit_valid(rx_bit_valid), .rx_bit(rx_bit)
	);

	spw_char_decoder u_decoder (
		.fpga_clk1_50(fpga_clk1_50), .arst_n(arst_n),
		.rx_bit_valid(rx_bit_valid), .rx_bit(rx_bit), .fifo_full(rx_full),
		.fifo_push(rx_push), .fifo_wdata(rx_word),
		.tick_out(tick_out), .time_out(time_out),
		.parity_error(parity_error), .rx_overflow(rx_overflow)
	);

	spw_fifo #(.fifo_depth(fifo_depth)) rx_fifo (
		.fpga_clk1_50(fpga_clk1_50), .arst_n(arst_n),
		.push(rx_push), .pop(rx_read), .wdata(rx_word),
		.rdata(rx_data), .full(rx_full), .empty(rx_empty), .count()
	);

endmodule

// File: source/spw_pkg.sv
package spw_pkg;

	// character widths
	localparam int unsigned nchar_w = 9; // fifo word, flag + byte
	localparam int unsigned time_w = 6; // time code value

	// 2-bit control codes, sent lsb first after the flag
	localparam logic [1:0] ctrl_fct = 2'd0; // flow control token
	localparam logic [1:0] ctrl_eop = 2'd1; // normal end of packet
	localparam logic [1:0] ctrl_eep = 2'd2; // error end of packet
	localparam logic [1:0] ctrl_esc = 2'd3; // escape, prefix for null and time code

	// marker codes carried in the low byte of a marker word
	localparam logic [7:0] marker_eop = 8'd0;
	localparam logic [7:0] marker_eep = 8'd1;

	// data view of a fifo word
	typedef struct packed {
		logic       flag; // 0 for data
		logic [7:0] data; // payload byte
	} spw_data_s;

	// marker view of a fifo word
	typedef struct packed {
		logic       flag; // 1 for eop/eep
		logic [7:0] code; // marker_eop or marker_eep
	} spw_marker_s;

	// one 9-bit word, read as data or marker depending on flag
	typedef union packed {
		spw_data_s   dat;
		spw_marker_s mrk;
	} spw_nchar_u;

endpackage

// File: vlog.f
source/spw_pkg.sv
source/spw_fifo.sv
source/spw_char_encoder.sv
source/spw_ds_tx.sv
source/spw_ds_rx.sv
source/spw_char_decoder.sv
source/spw_link_top.sv
sim/spw_link_tb.sv
